// File: rtl/cordic_fmt_pkg.sv
// 12-bit signed S-format data throughout, sums wrap silently, six iterations fixed at build time
package cordic_fmt_pkg;

    //////////////////////////////////////////////////////////////////////
    // data path format
    //////////////////////////////////////////////////////////////////////

    // width of i_x/i_y, o_x/o_y and the internal x/y registers
    localparam int DATA_W = 12;

    // one vector component, two's complement
    typedef logic signed [DATA_W-1:0] cordic_data_t;

    //////////////////////////////////////////////////////////////////////
    // iteration control
    //////////////////////////////////////////////////////////////////////

    // number of micro-rotations per job
    // counter rests at this value between jobs
    localparam int ITER_N = 6;

    // counter must hold 0..ITER_N inclusive
    localparam int CNT_W = 3;

    typedef logic [CNT_W-1:0] cordic_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // gain compensation
    //////////////////////////////////////////////////////////////////////

    // 1/K approximated as 2^-1 + 2^-3 = 0.625
    // true value after six steps is about 0.6073
    localparam int GAIN_SHIFT_A = 1;
    localparam int GAIN_SHIFT_B = 3;

endpackage

// File: rtl/cordic_ctrl_pkg.sv
// mode encoding matches the i_mode pin, table count is fixed at two with a one-bit select
package cordic_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // operating mode
    //////////////////////////////////////////////////////////////////////

    // vectoring drives y to zero and records directions
    // rotation replays a recorded table onto a new vector
    typedef enum logic {
        MODE_ROTATION  = 1'b0,
        MODE_VECTORING = 1'b1
    } cordic_mode_e;

    //////////////////////////////////////////////////////////////////////
    // direction tables
    //////////////////////////////////////////////////////////////////////

    // two independent tables, picked by i_select
    localparam int TABLE_N = 2;
    localparam int TABLE_SEL_W = 1;

    // entries 0..ITER_N-1 are step directions
    // entry ITER_N is the half-plane fold done at load
    localparam int DIR_BITS = cordic_fmt_pkg::ITER_N + 1;

endpackage

// File: rtl/iteration_sequencer.sv
// a trigger during a running job restarts it, no back-pressure, o_load is combinational from i_trig
`timescale 1ns/1ns

module iteration_sequencer
    import cordic_fmt_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_trig,
    output logic        o_load,
    output logic        o_step,
    output logic        o_idle,
    output logic        o_done,
    output cordic_cnt_t o_iter
);

    cordic_cnt_t cnt_q;

    // idle once the counter parks at ITER_N
    assign o_idle = (cnt_q == cordic_cnt_t'(ITER_N));

    // trigger wins over a running step, so a restart never steps
    assign o_load = i_trig;
    assign o_step = !i_trig && (cnt_q < cordic_cnt_t'(ITER_N));
    assign o_iter = cnt_q;

    //////////////////////////////////////////////////////////////////////
    // iteration counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cnt_q <= cordic_cnt_t'(ITER_N);
        end else if (o_load) begin
            cnt_q <= '0;
        end else if (o_step) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // done goes high for the cycle after the last step edge
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_done <= 1'b0;
        end else begin
            o_done <= o_step && (cnt_q == cordic_cnt_t'(ITER_N - 1));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // counter never runs past the idle value
    a_cnt_range: assert property (@(posedge i_clk) disable iff (i_rst)
        cnt_q <= cordic_cnt_t'(ITER_N));

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |=> !o_done);

endmodule

// File: rtl/micro_rotation_unit.sv
// no guard bits, so inputs near full scale can overflow and wrap during the six steps
`timescale 1ns/1ns

module micro_rotation_unit
    import cordic_fmt_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_load,
    input  logic         i_step,
    input  logic         i_dir,
    input  logic         i_flip,
    input  cordic_cnt_t  i_iter,
    input  cordic_data_t i_x,
    input  cordic_data_t i_y,
    output cordic_data_t o_x_acc,
    output cordic_data_t o_y_acc,
    output logic         o_y_sign
);

    cordic_data_t x_q;
    cordic_data_t y_q;

    // shifted copies for the current iteration
    cordic_data_t x_sh;
    cordic_data_t y_sh;

    // candidate next values
    cordic_data_t x_rot;
    cordic_data_t y_rot;
    cordic_data_t x_ld;
    cordic_data_t y_ld;

    //////////////////////////////////////////////////////////////////////
    // pre-rotation load
    //////////////////////////////////////////////////////////////////////

    // flip by 180 deg so x starts in the right half-plane
    // -(-2048) wraps back to -2048, left as is
    always_comb begin
        if (i_flip) begin
            x_ld = -i_x;
            y_ld = -i_y;
        end else begin
            x_ld = i_x;
            y_ld = i_y;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // shift-add micro-rotation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // arithmetic shift keeps the sign
        x_sh = x_q >>> i_iter;
        y_sh = y_q >>> i_iter;
        if (i_dir) begin
            // y negative in vectoring, rotate counter-clockwise
            x_rot = x_q - y_sh;
            y_rot = y_q + x_sh;
        end else begin
            // rotate clockwise
            x_rot = x_q + y_sh;
            y_rot = y_q - x_sh;
        end
    end

    // x/y registers, one update per strobe
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            x_q <= '0;
            y_q <= '0;
        end else if (i_load) begin
            x_q <= x_ld;
            y_q <= y_ld;
        end else if (i_step) begin
            x_q <= x_rot;
            y_q <= y_rot;
        end
    end

    assign o_x_acc  = x_q;
    assign o_y_acc  = y_q;
    assign o_y_sign = y_q[DATA_W-1];

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // sequencer must never step with the idle index
    a_step_iter: assert property (@(posedge i_clk) disable iff (i_rst)
        i_step |-> (i_iter < cordic_cnt_t'(ITER_N)));

endmodule

// File: rtl/direction_memory.sv
// i_mode and i_select must hold from the trigger edge to the last step, rotation never writes
`timescale 1ns/1ns

module direction_memory
    import cordic_fmt_pkg::*, cordic_ctrl_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_load,
    input  logic                   i_step,
    input  logic                   i_x_sign,
    input  logic                   i_y_sign,
    input  cordic_mode_e           i_mode,
    input  logic [TABLE_SEL_W-1:0] i_select,
    input  cordic_cnt_t            i_iter,
    output logic                   o_dir,
    output logic                   o_flip
);

    // one row per table, bit ITER_N is the fold flag
    logic [DIR_BITS-1:0] tbl_q [TABLE_N];

    logic vectoring;

    assign vectoring = (i_mode == MODE_VECTORING);

    //////////////////////////////////////////////////////////////////////
    // direction select
    //////////////////////////////////////////////////////////////////////

    // live signs in vectoring, recorded bits in rotation
    assign o_flip = vectoring ? i_x_sign : tbl_q[i_select][ITER_N];
    assign o_dir  = vectoring ? i_y_sign : tbl_q[i_select][i_iter];

    // record on the same edge the datapath uses the bit
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int t = 0; t < TABLE_N; t++) begin
                tbl_q[t] <= '0;
            end
        end else if (vectoring) begin
            if (i_load) begin
                tbl_q[i_select][ITER_N] <= i_x_sign;
            end else if (i_step) begin
                tbl_q[i_select][i_iter] <= i_y_sign;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // mode and table held steady since the previous edge of the job
    a_ctrl_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        i_step |-> ($stable(i_mode) && $stable(i_select)));

endmodule

// File: rtl/gain_compensator.sv
// coarse 0.625 gain only, result truncated to 12 bits, outputs read zero while a job runs
`timescale 1ns/1ns

module gain_compensator
    import cordic_fmt_pkg::*;
(
    input  logic         i_idle,
    input  cordic_data_t i_x_acc,
    input  cordic_data_t i_y_acc,
    output cordic_data_t o_x,
    output cordic_data_t o_y
);

    // scaled components before gating
    cordic_data_t x_scaled;
    cordic_data_t y_scaled;

    //////////////////////////////////////////////////////////////////////
    // gain scaling
    //////////////////////////////////////////////////////////////////////

    // v*0.625 as two arithmetic shifts
    // each shift truncates toward -inf, so small negatives bias low
    always_comb begin
        x_scaled = (i_x_acc >>> GAIN_SHIFT_A) + (i_x_acc >>> GAIN_SHIFT_B);
        y_scaled = (i_y_acc >>> GAIN_SHIFT_A) + (i_y_acc >>> GAIN_SHIFT_B);
    end

    //////////////////////////////////////////////////////////////////////
    // output gating
    //////////////////////////////////////////////////////////////////////

    // intermediate x/y stay hidden until the counter parks
    always_comb begin
        if (i_idle) begin
            o_x = x_scaled;
            o_y = y_scaled;
        end else begin
            o_x = '0;
            o_y = '0;
        end
    end

endmodule

// File: rtl/cordic_engine.sv
// done pulse one cycle after the sixth step edge, outputs valid from then until the next trigger
`timescale 1ns/1ns

module cordic_engine
    import cordic_fmt_pkg::*, cordic_ctrl_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_trig,
    input  cordic_mode_e i_mode,
    input  logic         i_select,
    input  cordic_data_t i_x,
    input  cordic_data_t i_y,
    output cordic_data_t o_x,
    output cordic_data_t o_y,
    output logic         o_done
);

    // sequencer strobes
    logic        load;
    logic        step;
    logic        idle;
    cordic_cnt_t iter;

    // direction bits toward the datapath
    logic dir;
    logic flip;

    // datapath state
    cordic_data_t x_acc;
    cordic_data_t y_acc;
    logic         y_sign;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    iteration_sequencer u_seq (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_trig (i_trig),
        .o_load (load),
        .o_step (step),
        .o_idle (idle),
        .o_done (o_done),
        .o_iter (iter)
    );

    direction_memory u_dirmem (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_load   (load),
        .i_step   (step),
        .i_x_sign (i_x[DATA_W-1]),
        .i_y_sign (y_sign),
        .i_mode   (i_mode),
        .i_select (i_select),
        .i_iter   (iter),
        .o_dir    (dir),
        .o_flip   (flip)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    micro_rotation_unit u_rot (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_load   (load),
        .i_step   (step),
        .i_dir    (dir),
        .i_flip   (flip),
        .i_iter   (iter),
        .i_x      (i_x),
        .i_y      (i_y),
        .o_x_acc  (x_acc),
        .o_y_acc  (y_acc),
        .o_y_sign (y_sign)
    );

    gain_compensator u_gain (
        .i_idle  (idle),
        .i_x_acc (x_acc),
        .i_y_acc (y_acc),
        .o_x     (o_x),
        .o_y     (o_y)
    );

endmodule

// File: tests/tb_clock_gen.sv
// free-running 20 ns clock, reset high from time zero for three rising edges
`timescale 1ns/1ns

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    // half period of the 20 ns clock
    localparam int HALF_PERIOD = 10;

    // clock starts low, first rising edge at 10 ns
    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // release reset on the third rising edge
    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// File: tests/tb_cordic_engine.sv
// jobs never overlap, so restart-on-trigger goes untested, expected values come from a model
`timescale 1ns/1ns

module tb_cordic_engine
    import cordic_fmt_pkg::*, cordic_ctrl_pkg::*;
();

    localparam logic [31:0] LFSR_SEED = 32'h6f12;
    localparam int RST_TIMEOUT  = 20;
    localparam int DONE_TIMEOUT = 20;
    localparam int RAND_JOBS    = 8;
    localparam int REPLAY_JOBS  = 4;

    logic         clk;
    logic         rst;
    logic         trig;
    cordic_mode_e mode;
    logic         sel;
    cordic_data_t x_in;
    cordic_data_t y_in;
    cordic_data_t x_out;
    cordic_data_t y_out;
    logic         done;

    // model state and check qualifiers
    logic [DIR_BITS-1:0] model_tbl [TABLE_N];
    cordic_data_t exp_x;
    cordic_data_t exp_y;
    logic         started;
    logic         res_valid;
    logic [31:0]  lfsr_q = LFSR_SEED;
    string        test_name;
    int           mismatch_count;
    int           failure_count;
    int           timeout_count;

    tb_clock_gen u_clk (
        .o_clk (clk),
        .o_rst (rst)
    );

    cordic_engine DUT (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_trig   (trig),
        .i_mode   (mode),
        .i_select (sel),
        .i_x      (x_in),
        .i_y      (y_in),
        .o_x      (x_out),
        .o_y      (y_out),
        .o_done   (done)
    );

    //////////////////////////////////////////////////////////////////////
    // error reporting and random source
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input int expv, input int actv);
        mismatch_count++;
        $display("Mismatch test=%s %s expected=%0d actual=%0d", test_name, what, expv, actv);
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("test %s: %s", test_name, msg);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[31]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // one full job, updates the model tables in vectoring
    task automatic model_job(input cordic_mode_e m, input logic s, input cordic_data_t xi,
                             input cordic_data_t yi, output cordic_data_t ex,
                             output cordic_data_t ey);
        logic         flip;
        logic         d;
        cordic_data_t xr;
        cordic_data_t yr;
        cordic_data_t xn;
        cordic_data_t yn;
        flip = (m == MODE_VECTORING) ? xi[DATA_W-1] : model_tbl[s][ITER_N];
        if (m == MODE_VECTORING) begin
            model_tbl[s][ITER_N] = flip;
        end
        // fold into the right half-plane, 12-bit wrap on -2048
        xr = flip ? -xi : xi;
        yr = flip ? -yi : yi;
        for (int k = 0; k < ITER_N; k++) begin
            d = (m == MODE_VECTORING) ? yr[DATA_W-1] : model_tbl[s][k];
            if (m == MODE_VECTORING) begin
                model_tbl[s][k] = d;
            end
            if (d) begin
                xn = xr - (yr >>> k);
                yn = yr + (xr >>> k);
            end else begin
                xn = xr + (yr >>> k);
                yn = yr - (xr >>> k);
            end
            xr = xn;
            yr = yn;
        end
        // 0.625 = 1/2 + 1/8
        ex = (xr >>> 1) + (xr >>> 3);
        ey = (yr >>> 1) + (yr >>> 3);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic wait_reset_release();
        int n;
        for (n = 0; n < RST_TIMEOUT && rst; n++) begin
            @(posedge clk);
        end
        if (rst) begin
            timeout_count++;
            $display("reset never released within %0d cycles", RST_TIMEOUT);
        end
    endtask

    task automatic wait_done(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < DONE_TIMEOUT; n++) begin
            @(posedge clk);
            if (done) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            timeout_count++;
            $display("test %s: o_done never came within %0d cycles", test_name, DONE_TIMEOUT);
        end
    endtask

    // one-cycle trigger, mode and select held until the next job
    task automatic run_job(input string name, input cordic_mode_e m, input logic s,
                           input cordic_data_t xi, input cordic_data_t yi);
        cordic_data_t ex;
        cordic_data_t ey;
        logic         ok;
        @(posedge clk);
        test_name = name;
        model_job(m, s, xi, yi, ex, ey);
        exp_x     <= ex;
        exp_y     <= ey;
        res_valid <= 1'b0;
        started   <= 1'b1;
        trig      <= 1'b1;
        mode      <= m;
        sel       <= s;
        x_in      <= xi;
        y_in      <= yi;
        @(posedge clk);
        trig <= 1'b0;
        wait_done(ok);
        res_valid <= ok;
        // idle edges so the hold check sees the result
        repeat (2) @(posedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // quiet outputs between reset and the first trigger
    a_reset_done: assert property (@(posedge clk) disable iff (rst) !started |-> !done)
        else report_failure("o_done high before any trigger");
    a_reset_x: assert property (@(posedge clk) disable iff (rst) !started |-> x_out == '0)
        else report_mismatch("o_x after reset", 0, $sampled(x_out));
    a_reset_y: assert property (@(posedge clk) disable iff (rst) !started |-> y_out == '0)
        else report_mismatch("o_y after reset", 0, $sampled(y_out));

    // done one cycle after the sixth step edge, single cycle wide
    a_done_timing: assert property (@(posedge clk) disable iff (rst)
        trig |=> !done [*ITER_N] ##1 done ##1 !done)
        else report_failure("o_done pulse not exactly one cycle after the last step");

    // intermediate values never visible
    a_busy_x: assert property (@(posedge clk) disable iff (rst)
        trig |=> (x_out == '0) [*ITER_N])
        else report_mismatch("o_x during job", 0, $sampled(x_out));
    a_busy_y: assert property (@(posedge clk) disable iff (rst)
        trig |=> (y_out == '0) [*ITER_N])
        else report_mismatch("o_y during job", 0, $sampled(y_out));

    // result at done and while it holds
    a_result_x: assert property (@(posedge clk) disable iff (rst)
        (done || res_valid) |-> x_out == exp_x)
        else report_mismatch("o_x", $sampled(exp_x), $sampled(x_out));
    a_result_y: assert property (@(posedge clk) disable iff (rst)
        (done || res_valid) |-> y_out == exp_y)
        else report_mismatch("o_y", $sampled(exp_y), $sampled(y_out));

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]  r;
        cordic_data_t vx;
        cordic_data_t vy;
        trig           = 1'b0;
        mode           = MODE_ROTATION;
        sel            = 1'b0;
        x_in           = '0;
        y_in           = '0;
        exp_x          = '0;
        exp_y          = '0;
        started        = 1'b0;
        res_valid      = 1'b0;
        test_name      = "reset";
        mismatch_count = 0;
        failure_count  = 0;
        timeout_count  = 0;
        for (int t = 0; t < TABLE_N; t++) begin
            model_tbl[t] = '0;
        end

        wait_reset_release();
        // a few idle edges for the reset checks
        repeat (4) @(posedge clk);

        // random vectoring, odd jobs forced to negative x
        for (int j = 0; j < RAND_JOBS; j++) begin
            take_bits(DATA_W, r);
            vx = r[DATA_W-1:0];
            take_bits(DATA_W, r);
            vy = r[DATA_W-1:0];
            if (j % 2 == 1) begin
                vx[DATA_W-1] = 1'b1;
            end
            run_job("vector_rand", MODE_VECTORING, j[0], vx, vy);
        end

        // record then replay on the same table
        for (int j = 0; j < REPLAY_JOBS; j++) begin
            take_bits(DATA_W, r);
            vx = r[DATA_W-1:0];
            take_bits(DATA_W, r);
            vy = r[DATA_W-1:0];
            run_job("replay_rec", MODE_VECTORING, 1'b0, vx, vy);
            take_bits(DATA_W, r);
            vx = r[DATA_W-1:0];
            take_bits(DATA_W, r);
            vy = r[DATA_W-1:0];
            run_job("replay_rot", MODE_ROTATION, 1'b0, vx, vy);
        end

        // distinct angles in each table, same vector rotated by both
        run_job("table0_vec", MODE_VECTORING, 1'b0, 12'sd900, -12'sd700);
        run_job("table1_vec", MODE_VECTORING, 1'b1, -12'sd800, 12'sd300);
        run_job("table0_rot", MODE_ROTATION, 1'b0, 12'sd600, 12'sd100);
        run_job("table1_rot", MODE_ROTATION, 1'b1, 12'sd600, 12'sd100);
        run_job("table0_again", MODE_ROTATION, 1'b0, -12'sd500, 12'sd450);

        repeat (3) @(posedge clk);
        $display("mismatches=%0d failures=%0d timeouts=%0d",
                 mismatch_count, failure_count, timeout_count);
        if (mismatch_count == 0 && failure_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/cordic_fmt_pkg.sv
rtl/cordic_ctrl_pkg.sv
rtl/iteration_sequencer.sv
rtl/micro_rotation_unit.sv
rtl/direction_memory.sv
rtl/gain_compensator.sv
rtl/cordic_engine.sv
tests/tb_clock_gen.sv
tests/tb_cordic_engine.sv

// File: Bender.yml
package:
  name: cordic_engine

sources:
  # packages first, the format package is used by the control package
  - rtl/cordic_fmt_pkg.sv
  - rtl/cordic_ctrl_pkg.sv

  # design blocks, top level last
  - rtl/iteration_sequencer.sv
  - rtl/micro_rotation_unit.sv
  - rtl/direction_memory.sv
  - rtl/gain_compensator.sv
  - rtl/cordic_engine.sv

  # testbench
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_cordic_engine.sv
